//--- verilog/mmc_proto_pkg.sv
package mmc_proto_pkg;

   // operations a host can ask of one card slot
   typedef enum logic [2:0] {
      op_init,
      op_cmd,
      op_wr,
      op_rd,
      op_stop
   } mmc_op_t;

   // full card command frame, sent msb first
   typedef logic [47:0] cmd_frame_t;

   typedef logic [7:0] byte_t;

   // counts clocked bit times within one phase
   typedef logic [7:0] bit_count_t;

   // phase lengths in bit times
   localparam bit_count_t CMD_BITS    = 8'd48;
   localparam bit_count_t BYTE_BITS   = 8'd8;
   localparam bit_count_t INIT_CLOCKS = 8'd80;
   localparam bit_count_t INIT_TOTAL  = 8'd100;

endpackage

//--- verilog/mmc_timing_pkg.sv
package mmc_timing_pkg;

   // slot index, wide enough for eight slots
   typedef logic [2:0] slot_t;

   // system clocks within one serial bit
   typedef logic [15:0] bit_time_t;

   // clocks per serial bit
   function automatic bit_time_t bit_width(input int freq, input int rate);
      return bit_time_t'(freq / rate);
   endfunction

   // clock count at which sclk rises and miso is sampled
   function automatic bit_time_t bit_middle(input int freq, input int rate);
      return bit_time_t'((freq / rate) / 2);
   endfunction

endpackage

//--- verilog/mmc_dispatch.sv
`timescale 1ns/1ps

module mmc_dispatch #(
   parameter int NUM_SLOTS = 4
)
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req,
   input  mmc_timing_pkg::slot_t     req_slot,
   input  mmc_proto_pkg::mmc_op_t    req_op,
   input  mmc_proto_pkg::cmd_frame_t req_cmd,
   input  mmc_proto_pkg::byte_t      req_data,
   input  logic [NUM_SLOTS-1:0]      done,
   output logic [NUM_SLOTS-1:0]      start,
   output mmc_proto_pkg::mmc_op_t    op,
   output mmc_proto_pkg::cmd_frame_t cmd,
   output mmc_proto_pkg::byte_t      data,
   output logic [NUM_SLOTS-1:0]      busy,
   output logic                      req_dropped
);

   logic [NUM_SLOTS-1:0] slot_hit;
   logic [NUM_SLOTS-1:0] grant;
   logic                 accept;

   // one-hot slot decode, all zero when out of range
   always_comb
   begin
      for (int i = 0; i < NUM_SLOTS; i++)
         slot_hit[i] = (req_slot == mmc_timing_pkg::slot_t'(i));
   end

   assign grant  = req ? (slot_hit & ~busy) : '0;
   assign accept = |grant;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         start       <= '0;
         busy        <= '0;
         req_dropped <= 1'b0;
      end
      else
      begin
         start       <= grant;
         busy        <= (busy & ~done) | grant;
         req_dropped <= req && !accept;
      end
   end

   // request fields broadcast to every engine
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         op   <= req_op;
         cmd  <= req_cmd;
         data <= req_data;
      end
   end

endmodule

//--- verilog/mmc_spi_engine.sv
`timescale 1ns/1ps

module mmc_spi_engine #(
   parameter int FREQ    = 100,
   parameter int RATE_HI = 25,
   parameter int RATE_LO = 10
)
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      speed,
   input  logic                      start,
   input  mmc_proto_pkg::mmc_op_t    op,
   input  mmc_proto_pkg::cmd_frame_t cmd,
   input  mmc_proto_pkg::byte_t      data,
   output logic                      done,
   output mmc_proto_pkg::byte_t      rd_byte,
   output logic                      card_sclk,
   output logic                      card_mosi,
   output logic                      card_cs_n,
   input  logic                      card_miso
);

   localparam mmc_timing_pkg::bit_time_t WIDTH_HI = mmc_timing_pkg::bit_width(FREQ, RATE_HI);
   localparam mmc_timing_pkg::bit_time_t MID_HI   = mmc_timing_pkg::bit_middle(FREQ, RATE_HI);
   localparam mmc_timing_pkg::bit_time_t WIDTH_LO = mmc_timing_pkg::bit_width(FREQ, RATE_LO);
   localparam mmc_timing_pkg::bit_time_t MID_LO   = mmc_timing_pkg::bit_middle(FREQ, RATE_LO);

   typedef enum logic [3:0] {
      s_idle,
      s_init_clk,
      s_init_idle,
      s_cmd_shift,
      s_wr_shift,
      s_rd_shift,
      s_stop_cs,
      s_stop_clk,
      s_tail,
      s_done
   } state_t;

   state_t                    state;
   state_t                    next_state;
   logic                      speed_hi;
   logic                      accept;
   logic                      timed;
   logic                      sclk_en;
   logic                      bit_mid;
   logic                      bit_end;
   logic                      last_bit;
   mmc_timing_pkg::bit_time_t bit_time;
   mmc_timing_pkg::bit_time_t width;
   mmc_timing_pkg::bit_time_t middle;
   mmc_proto_pkg::bit_count_t bit_count;
   mmc_proto_pkg::bit_count_t phase_bits;
   mmc_proto_pkg::cmd_frame_t shift_out;

   always_ff @(posedge clk)
   begin
      if (reset)
         speed_hi <= 1'b0;
      else
         speed_hi <= speed;
   end

   assign width  = speed_hi ? WIDTH_HI : WIDTH_LO;
   assign middle = speed_hi ? MID_HI : MID_LO;

   assign accept  = (state == s_idle) && start;
   assign timed   = state inside {s_init_clk, s_init_idle, s_cmd_shift, s_wr_shift,
                                  s_rd_shift, s_stop_cs, s_stop_clk};
   // init_idle and stop_cs keep bit time with the clock parked low
   assign sclk_en = state inside {s_init_clk, s_cmd_shift, s_wr_shift, s_rd_shift,
                                  s_stop_clk};
   assign bit_mid = timed && (bit_time == middle - 1'b1);
   assign bit_end = timed && (bit_time >= width - 1'b1);

   always_comb
   begin
      case (state)
         s_init_clk:  phase_bits = mmc_proto_pkg::INIT_CLOCKS;
         s_init_idle: phase_bits = mmc_proto_pkg::INIT_TOTAL;
         s_cmd_shift: phase_bits = mmc_proto_pkg::CMD_BITS;
         s_stop_cs:   phase_bits = 8'd1;
         default:     phase_bits = mmc_proto_pkg::BYTE_BITS;
      endcase
   end

   assign last_bit = bit_end && (bit_count == phase_bits - 1'b1);

   always_comb
   begin
      next_state = state;
      case (state)
         s_idle:
            if (start)
            begin
               case (op)
                  mmc_proto_pkg::op_init: next_state = s_init_clk;
                  mmc_proto_pkg::op_cmd:  next_state = s_cmd_shift;
                  mmc_proto_pkg::op_wr:   next_state = s_wr_shift;
                  mmc_proto_pkg::op_rd:   next_state = s_rd_shift;
                  mmc_proto_pkg::op_stop: next_state = s_stop_cs;
                  // unknown op still completes
                  default:                next_state = s_tail;
               endcase
            end
         s_init_clk:
            if (last_bit)
               next_state = s_init_idle;
         s_stop_cs:
            if (last_bit)
               next_state = s_stop_clk;
         s_init_idle, s_cmd_shift, s_wr_shift, s_rd_shift, s_stop_clk:
            if (last_bit)
               next_state = s_tail;
         s_tail:
            if (bit_time == 16'd1)
               next_state = s_done;
         default:
            next_state = s_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= s_idle;
      else
         state <= next_state;
   end

   // bit timer, also paces the two tail cycles
   always_ff @(posedge clk)
   begin
      if (reset)
         bit_time <= '0;
      else if (state == s_idle || state == s_done || bit_end)
         bit_time <= '0;
      else
         bit_time <= bit_time + 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         bit_count <= '0;
      else if (state == s_idle || (state == s_stop_cs && last_bit))
         bit_count <= '0;
      else if (bit_end)
         bit_count <= bit_count + 1'b1;
   end

   // low first half, high from midpoint to bit end
   always_ff @(posedge clk)
   begin
      if (reset)
         card_sclk <= 1'b0;
      else
         card_sclk <= sclk_en && (bit_mid || (card_sclk && !bit_end));
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         shift_out <= (op == mmc_proto_pkg::op_wr) ? {data, 40'd0} : cmd;
      else if (bit_end)
         shift_out <= {shift_out[46:0], 1'b0};
   end

   // mosi moves at bit start, idles high
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         card_mosi <= 1'b1;
         card_cs_n <= 1'b1;
      end
      else if (accept)
      begin
         case (op)
            mmc_proto_pkg::op_cmd:
            begin
               card_cs_n <= 1'b0;
               card_mosi <= cmd[47];
            end
            mmc_proto_pkg::op_wr:
               card_mosi <= data[7];
            mmc_proto_pkg::op_init, mmc_proto_pkg::op_stop:
            begin
               card_cs_n <= 1'b1;
               card_mosi <= 1'b1;
            end
            default:
               card_mosi <= 1'b1;
         endcase
      end
      else if (bit_end && (state == s_cmd_shift || state == s_wr_shift))
         card_mosi <= last_bit ? 1'b1 : shift_out[46];
   end

   // sample miso as sclk rises
   always_ff @(posedge clk)
   begin
      if (accept)
         rd_byte <= '0;
      else if (state == s_rd_shift && bit_mid)
         rd_byte <= {rd_byte[6:0], card_miso};
   end

   assign done = (state == s_done);

endmodule

//--- verilog/mmc_collect.sv
`timescale 1ns/1ps

module mmc_collect #(
   parameter int NUM_SLOTS = 4
)
(
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic [NUM_SLOTS-1:0]                  done,
   input  mmc_proto_pkg::byte_t [NUM_SLOTS-1:0]  rd_byte,
   output logic                                  resp_valid,
   output mmc_timing_pkg::slot_t                 resp_slot,
   output mmc_proto_pkg::byte_t                  resp_data
);

   logic [NUM_SLOTS-1:0]                 pending;
   logic [NUM_SLOTS-1:0]                 grant;
   mmc_proto_pkg::byte_t [NUM_SLOTS-1:0] held;

   // lowest pending slot wins, scan from the top down
   always_comb
   begin
      grant     = '0;
      resp_slot = '0;
      resp_data = held[0];
      for (int i = NUM_SLOTS - 1; i >= 0; i--)
      begin
         if (pending[i])
         begin
            grant     = '0;
            grant[i]  = 1'b1;
            resp_slot = mmc_timing_pkg::slot_t'(i);
            resp_data = held[i];
         end
      end
   end

   assign resp_valid = |pending;

   always_ff @(posedge clk)
   begin
      if (reset)
         pending <= '0;
      else
         pending <= (pending & ~grant) | done;
   end

   // byte is captured since the engine may restart before draining
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < NUM_SLOTS; i++)
      begin
         if (done[i])
            held[i] <= rd_byte[i];
      end
   end

endmodule

//--- verilog/mmc_multi_top.sv
`timescale 1ns/1ps

module mmc_multi_top #(
   parameter int NUM_SLOTS = 4,
   parameter int FREQ      = 100,
   parameter int RATE_HI   = 25,
   parameter int RATE_LO   = 10
)
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req,
   input  mmc_timing_pkg::slot_t     req_slot,
   input  mmc_proto_pkg::mmc_op_t    req_op,
   input  mmc_proto_pkg::cmd_frame_t req_cmd,
   input  mmc_proto_pkg::byte_t      req_data,
   input  logic                      speed,
   output logic                      resp_valid,
   output mmc_timing_pkg::slot_t     resp_slot,
   output mmc_proto_pkg::byte_t      resp_data,
   output logic                      req_dropped,
   output logic [NUM_SLOTS-1:0]      busy,
   output logic [NUM_SLOTS-1:0]      card_sclk,
   output logic [NUM_SLOTS-1:0]      card_mosi,
   output logic [NUM_SLOTS-1:0]      card_cs_n,
   input  logic [NUM_SLOTS-1:0]      card_miso
);

   logic [NUM_SLOTS-1:0]                 start;
   logic [NUM_SLOTS-1:0]                 done;
   mmc_proto_pkg::mmc_op_t               op;
   mmc_proto_pkg::cmd_frame_t            cmd;
   mmc_proto_pkg::byte_t                 data;
   mmc_proto_pkg::byte_t [NUM_SLOTS-1:0] rd_byte;

   mmc_dispatch #(
      .NUM_SLOTS(NUM_SLOTS)
   ) u_dispatch (
      .clk(clk),
      .reset(reset),
      .req(req),
      .req_slot(req_slot),
      .req_op(req_op),
      .req_cmd(req_cmd),
      .req_data(req_data),
      .done(done),
      .start(start),
      .op(op),
      .cmd(cmd),
      .data(data),
      .busy(busy),
      .req_dropped(req_dropped)
   );

   // one engine per card slot
   for (genvar g = 0; g < NUM_SLOTS; g++)
   begin : g_slot
      mmc_spi_engine #(
         .FREQ(FREQ),
         .RATE_HI(RATE_HI),
         .RATE_LO(RATE_LO)
      ) u_engine (
         .clk(clk),
         .reset(reset),
         .speed(speed),
         .start(start[g]),
         .op(op),
         .cmd(cmd),
         .data(data),
         .done(done[g]),
         .rd_byte(rd_byte[g]),
         .card_sclk(card_sclk[g]),
         .card_mosi(card_mosi[g]),
         .card_cs_n(card_cs_n[g]),
         .card_miso(card_miso[g])
      );
   end

   mmc_collect #(
      .NUM_SLOTS(NUM_SLOTS)
   ) u_collect (
      .clk(clk),
      .reset(reset),
      .done(done),
      .rd_byte(rd_byte),
      .resp_valid(resp_valid),
      .resp_slot(resp_slot),
      .resp_data(resp_data)
   );

endmodule

//--- verif/mmc_card_model.sv
`timescale 1ns/1ps

module mmc_card_model
(
   input  logic        sclk,
   input  logic        mosi,
   input  logic        cs_n,
   input  logic        clear,
   input  logic [7:0]  reply,
   output logic        miso,
   output int          edges,
   output int          cs_high,
   output int          cs_low,
   output logic [47:0] bits
);

   // falling edges seen since the last clear
   int falls;

   // count rising edges and log mosi and chip select
   always @(posedge sclk or posedge clear)
   begin
      if (clear)
      begin
         edges   <= 0;
         cs_high <= 0;
         cs_low  <= 0;
         bits    <= '0;
      end
      else
      begin
         edges <= edges + 1;
         bits  <= {bits[46:0], mosi};
         if (cs_n)
            cs_high <= cs_high + 1;
         else
            cs_low <= cs_low + 1;
      end
   end

   // reply bits step on each falling edge
   always @(negedge sclk or posedge clear)
   begin
      if (clear)
         falls <= 0;
      else
         falls <= falls + 1;
   end

   // reply msb leads, miso idles high after the last bit
   assign miso = (falls < 8) ? reply[7 - falls] : 1'b1;

endmodule

//--- verif/mmc_multi_sva.sv
`timescale 1ns/1ps

module mmc_multi_sva #(
   parameter int NUM_SLOTS = 4
)
(
   input logic                 clk,
   input logic                 reset,
   input logic [NUM_SLOTS-1:0] start,
   input logic [NUM_SLOTS-1:0] done,
   input logic [NUM_SLOTS-1:0] busy,
   input logic [NUM_SLOTS-1:0] card_sclk,
   input logic                 resp_valid
);

   // completions not yet seen on the response port
   int unsent;

   always_ff @(posedge clk)
   begin
      if (reset)
         unsent <= 0;
      else
         unsent <= unsent + $countones(done) - (resp_valid ? 1 : 0);
   end

   start_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(start))
      else $error("start drives more than one slot");

   resp_needs_pending: assert property (@(posedge clk) disable iff (reset)
      resp_valid |-> unsent > 0)
      else $error("resp_valid with no completion pending");

   // idle slots keep their serial clock parked
   sclk_idle_low: assert property (@(posedge clk) disable iff (reset)
      (card_sclk & ~busy) == '0)
      else $error("card_sclk toggles on a slot that is not busy");

endmodule

bind mmc_multi_top mmc_multi_sva #(
   .NUM_SLOTS(NUM_SLOTS)
) u_sva (
   .clk(clk),
   .reset(reset),
   .start(start),
   .done(done),
   .busy(busy),
   .card_sclk(card_sclk),
   .resp_valid(resp_valid)
);

//--- verif/tb_mmc_multi.sv
`timescale 1ns/1ps

module tb_mmc_multi;

   localparam int NUM_SLOTS = 4;
   localparam int FREQ      = 100;
   localparam int RATE_HI   = 25;
   localparam int RATE_LO   = 10;

   logic                      clk;
   logic                      reset;
   logic                      req;
   mmc_timing_pkg::slot_t     req_slot;
   mmc_proto_pkg::mmc_op_t    req_op;
   mmc_proto_pkg::cmd_frame_t req_cmd;
   mmc_proto_pkg::byte_t      req_data;
   logic                      speed;
   logic                      resp_valid;
   mmc_timing_pkg::slot_t     resp_slot;
   mmc_proto_pkg::byte_t      resp_data;
   logic                      req_dropped;
   logic [NUM_SLOTS-1:0]      busy;
   logic [NUM_SLOTS-1:0]      card_sclk;
   logic [NUM_SLOTS-1:0]      card_mosi;
   logic [NUM_SLOTS-1:0]      card_cs_n;
   logic [NUM_SLOTS-1:0]      card_miso;

   // card model controls and records
   logic [NUM_SLOTS-1:0] clear;
   logic [7:0]           reply [NUM_SLOTS];
   int                   edges [NUM_SLOTS];
   int                   cs_high [NUM_SLOTS];
   int                   cs_low [NUM_SLOTS];
   logic [47:0]          bits [NUM_SLOTS];

   // one entry per stimulus line
   int          ln_slot[$];
   int          ln_op[$];
   logic [47:0] ln_cmd[$];
   logic [7:0]  ln_wr[$];
   logic [7:0]  ln_reply[$];
   logic [7:0]  ln_exp[$];
   int          ln_drop[$];
   int          ln_speed[$];
   int          ln_gap[$];

   // accepted requests still waiting for resp_valid
   int     pend_line[$];
   longint pend_end[$];

   longint cycle = 0;
   bit     loaded = 0;

   mmc_multi_top #(
      .NUM_SLOTS(NUM_SLOTS),
      .FREQ(FREQ),
      .RATE_HI(RATE_HI),
      .RATE_LO(RATE_LO)
   ) UUT (
      .clk(clk),
      .reset(reset),
      .req(req),
      .req_slot(req_slot),
      .req_op(req_op),
      .req_cmd(req_cmd),
      .req_data(req_data),
      .speed(speed),
      .resp_valid(resp_valid),
      .resp_slot(resp_slot),
      .resp_data(resp_data),
      .req_dropped(req_dropped),
      .busy(busy),
      .card_sclk(card_sclk),
      .card_mosi(card_mosi),
      .card_cs_n(card_cs_n),
      .card_miso(card_miso)
   );

   for (genvar g = 0; g < NUM_SLOTS; g++)
   begin : g_card
      mmc_card_model u_card (
         .sclk(card_sclk[g]),
         .mosi(card_mosi[g]),
         .cs_n(card_cs_n[g]),
         .clear(clear[g]),
         .reply(reply[g]),
         .miso(card_miso[g]),
         .edges(edges[g]),
         .cs_high(cs_high[g]),
         .cs_low(cs_low[g]),
         .bits(bits[g])
      );
   end

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk)
      cycle <= cycle + 1;

   // system clocks per serial bit
   function automatic int bit_clocks(input int fast);
      return (fast != 0) ? FREQ / RATE_HI : FREQ / RATE_LO;
   endfunction

   // bit times an operation occupies, stop includes its cs bit
   function automatic int frame_bits(input int op);
      case (op)
         0:       return 100;
         1:       return 48;
         4:       return 9;
         default: return 8;
      endcase
   endfunction

   function automatic int edge_count(input int op);
      case (op)
         0:       return 80;
         1:       return 48;
         default: return 8;
      endcase
   endfunction

   task automatic report_error(input string what);
      $display("ERROR: %s", what);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [47:0] got, input logic [47:0] exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   task automatic load_stimulus();
      int          fd;
      int          code;
      string       line;
      int          s;
      int          o;
      int          d;
      int          sp;
      int          g;
      logic [47:0] c;
      logic [7:0]  w;
      logic [7:0]  r;
      logic [7:0]  e;
      fd = $fopen("verif/mmc_stim.txt", "r");
      if (fd == 0)
         report_error("cannot open verif/mmc_stim.txt");
      while (fd != 0 && !$feof(fd))
      begin
         code = $fgets(line, fd);
         if (code > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                 s, o, c, w, r, e, d, sp, g) == 9)
         begin
            ln_slot.push_back(s);
            ln_op.push_back(o);
            ln_cmd.push_back(c);
            ln_wr.push_back(w);
            ln_reply.push_back(r);
            ln_exp.push_back(e);
            ln_drop.push_back(d);
            ln_speed.push_back(sp);
            ln_gap.push_back(g);
         end
      end
      if (fd != 0)
         $fclose(fd);
   endtask

   // earliest finishing request answers first, lower slot on a tie
   task automatic match_response();
      int best;
      int ln;
      int s;
      best = 0;
      for (int k = 1; k < pend_line.size(); k++)
      begin
         if (pend_end[k] < pend_end[best] ||
             (pend_end[k] == pend_end[best] &&
              ln_slot[pend_line[k]] < ln_slot[pend_line[best]]))
            best = k;
      end
      ln = pend_line[best];
      s  = ln_slot[ln];
      check("resp_slot", resp_slot, s);
      check("resp_data", resp_data, ln_exp[ln]);
      check($sformatf("card_sclk[%0d] edges", s), edges[s], edge_count(ln_op[ln]));
      case (ln_op[ln])
         0, 4:
            check($sformatf("card_cs_n[%0d] high edges", s), cs_high[s],
                  edge_count(ln_op[ln]));
         1:
         begin
            check($sformatf("card_cs_n[%0d] low edges", s), cs_low[s], 48);
            check($sformatf("card_mosi[%0d]", s), bits[s], ln_cmd[ln]);
         end
         2:
            check($sformatf("card_mosi[%0d]", s), bits[s][7:0], ln_wr[ln]);
         default:
            ;
      endcase
      pend_line.delete(best);
      pend_end.delete(best);
   endtask

   task automatic wait_drained();
      while (pend_line.size() != 0)
         @(negedge clk);
   endtask

   always @(negedge clk)
   begin
      if (!reset && resp_valid)
      begin
         if (pend_line.size() == 0)
            report_error("resp_valid with no request outstanding");
         else
            match_response();
      end
   end

   initial
   begin
      int limit;
      wait (loaded);
      limit = ln_slot.size() * 110 * (FREQ / RATE_LO) + 1000;
      repeat (limit) @(posedge clk);
      $display("ERROR: run did not finish within %0d cycles", limit);
      $display("Simulation FAILED");
      $fatal(1);
   end

   initial
   begin
      reset    = 1'b1;
      req      = 1'b0;
      req_slot = '0;
      req_op   = mmc_proto_pkg::op_init;
      req_cmd  = '0;
      req_data = '0;
      speed    = 1'b0;
      clear    = '0;
      for (int k = 0; k < NUM_SLOTS; k++)
         reply[k] = 8'hff;
      void'($urandom(8));
      load_stimulus();
      if (ln_slot.size() == 0)
         report_error("stimulus file holds no requests");
      loaded = 1'b1;
      @(negedge clk);
      clear = '1;
      @(negedge clk);
      clear = '0;
      reset = 1'b0;

      for (int i = 0; i < ln_slot.size(); i++)
      begin
         speed    = (ln_speed[i] != 0);
         req      = 1'b1;
         req_slot = mmc_timing_pkg::slot_t'(ln_slot[i]);
         req_op   = mmc_proto_pkg::mmc_op_t'(ln_op[i]);
         req_cmd  = ln_cmd[i];
         req_data = ln_wr[i];
         // a dropped request must leave the card record alone
         if (ln_drop[i] == 0)
         begin
            reply[ln_slot[i]] = ln_reply[i];
            clear[ln_slot[i]] = 1'b1;
            pend_line.push_back(i);
            pend_end.push_back(cycle + frame_bits(ln_op[i]) * bit_clocks(ln_speed[i]));
         end
         @(negedge clk);
         req   = 1'b0;
         clear = '0;
         check("req_dropped", req_dropped, ln_drop[i]);
         if (ln_drop[i] == 0)
            check("busy", busy[ln_slot[i]], 1);
         if (ln_gap[i] == 0)
         begin
            wait_drained();
            repeat ($urandom % 4 + 1) @(negedge clk);
         end
         else
            repeat (ln_gap[i] - 1) @(negedge clk);
      end

      wait_drained();
      check("busy", busy, 0);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- verif/mmc_stim.txt
# slot op cmd wr_byte reply expect drop speed gap, all hex
# op 0 init 1 cmd 2 write 3 read 4 stop, speed 1 fast, gap 0 waits for all responses
0 0 000000000000 00 00 00 0 0 0
1 0 000000000000 00 00 00 0 1 0
0 1 400000000095 00 00 00 0 0 0
0 2 000000000000 a5 00 00 0 0 0
0 3 000000000000 00 3c 3c 0 0 0
0 3 000000000000 00 c7 c7 0 1 0
1 1 48000001aa87 00 00 00 0 1 0
2 1 7a0000000075 00 00 00 0 1 3
2 2 000000000000 5e 00 00 1 1 0
1 4 000000000000 00 00 00 0 1 4
0 3 000000000000 00 5a 5a 0 1 0
3 3 000000000000 00 81 81 0 1 1
2 3 000000000000 00 42 42 0 1 1
1 3 000000000000 00 18 18 0 1 1
0 3 000000000000 00 e7 e7 0 1 0
3 4 000000000000 00 00 00 0 0 0

//--- verilog.f
verilog/mmc_proto_pkg.sv
verilog/mmc_timing_pkg.sv
verilog/mmc_dispatch.sv
verilog/mmc_spi_engine.sv
verilog/mmc_collect.sv
verilog/mmc_multi_top.sv
verif/mmc_card_model.sv
verif/mmc_multi_sva.sv
verif/tb_mmc_multi.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_mmc_multi
FILELIST = verilog.f
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
